/* dpm_pkg.sv */
// -------------------------------------
// Shared widths and types for the datapath memory subsystem.
// Memory indices travel at full address width; banks keep only
// the low MEM_ADDR_WIDTH bits, so window bases must be aligned.
// At most 2**PORT_SEL_WIDTH I/O ports per bank.
// -------------------------------------

`default_nettype none

package dpm_pkg;

    // Widths and limits
    localparam int ADDR_WIDTH     = 10;
    localparam int WORD_WIDTH     = 32;
    localparam int PORT_SEL_WIDTH = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // -------------------------------------
    // One bank's share of a datapath operation

    typedef struct packed {
        addr_t read_addr;
        logic  write_en;
        addr_t write_addr;
        word_t write_data;
    } bank_op_t;

    // -------------------------------------
    // Decoded request, one per bank, registered in the decoder
    // Exactly one of read_mem/read_io (or none, for the zero location)

    typedef struct packed {
        logic                      valid;
        logic                      read_mem;
        logic                      read_io;
        logic [PORT_SEL_WIDTH-1:0] read_port;
        logic                      write_mem;
        logic                      write_io;
        logic [PORT_SEL_WIDTH-1:0] write_port;
        addr_t                     mem_read_index;
        addr_t                     mem_write_index;
        word_t                     write_data;
    } bank_req_t;

    // -------------------------------------
    // Bank result toward the read collector

    typedef struct packed {
        logic  valid;
        logic  read_en;
        word_t data;
        logic  io_wren_any;
    } bank_rsp_t;

endpackage

`default_nettype wire

/* operand_decode.sv */
// -------------------------------------
// Registers each operation and classifies its addresses per bank.
// Windows are clipped to the smaller of the read/write ranges.
// Assumes bound >= base and an I/O window outside the memory window.
// This is the only address comparison in the subsystem.
// -------------------------------------

`timescale 1ns/1ps
`default_nettype none

module operand_decode #(
    parameter int unsigned BANK_COUNT     = 2,
    parameter int unsigned READ_BASE      = 0,
    parameter int unsigned READ_BOUND     = 191,
    parameter int unsigned WRITE_BASE     = 0,
    parameter int unsigned WRITE_BOUND    = 255,
    parameter int unsigned MEM_ADDR_WIDTH = 8,
    parameter int unsigned IO_PORT_COUNT  = 4,
    parameter int unsigned IO_PORT_BASE   = 'h200
) (
    input  wire                                   clock,
    input  wire                                   arst_n,
    input  wire                                   op_valid,
    input  dpm_pkg::bank_op_t  [BANK_COUNT-1:0]   op,
    output dpm_pkg::bank_req_t [BANK_COUNT-1:0]   req
);

    // Memory depth from the narrower window
    localparam int unsigned READ_DEPTH  = READ_BOUND - READ_BASE + 1;
    localparam int unsigned WRITE_DEPTH = WRITE_BOUND - WRITE_BASE + 1;
    localparam int unsigned MEM_DEPTH   = (READ_DEPTH <= WRITE_DEPTH) ? READ_DEPTH : WRITE_DEPTH;

    // Keeps the low bits that index the RAM
    localparam dpm_pkg::addr_t INDEX_MASK = dpm_pkg::addr_t'((1 << MEM_ADDR_WIDTH) - 1);

    // -------------------------------------
    // Address helpers

    // One extra bit so an address below base wraps to a large offset
    function automatic logic [dpm_pkg::ADDR_WIDTH:0] window_offset(
        input dpm_pkg::addr_t a,
        input int unsigned    base
    );
        return {1'b0, a} - base[dpm_pkg::ADDR_WIDTH:0];
    endfunction

    function automatic logic in_window(
        input dpm_pkg::addr_t a,
        input int unsigned    base,
        input int unsigned    count
    );
        return 32'(window_offset(a, base)) < count;
    endfunction

    function automatic logic [dpm_pkg::PORT_SEL_WIDTH-1:0] port_of(input dpm_pkg::addr_t a);
        logic [dpm_pkg::ADDR_WIDTH:0] off;
        off = window_offset(a, IO_PORT_BASE);
        return off[dpm_pkg::PORT_SEL_WIDTH-1:0];
    endfunction

    // -------------------------------------
    // Classification

    dpm_pkg::bank_req_t [BANK_COUNT-1:0] req_d;

    always_comb begin
        for (int i = 0; i < BANK_COUNT; i++) begin
            req_d[i] = '0;
            req_d[i].valid = op_valid;

            // Reads go to memory, an I/O port or neither (zero location)
            req_d[i].read_mem  = op_valid && in_window(op[i].read_addr, READ_BASE, MEM_DEPTH);
            req_d[i].read_io   = op_valid &&
                                 in_window(op[i].read_addr, IO_PORT_BASE, IO_PORT_COUNT);
            req_d[i].read_port = port_of(op[i].read_addr);

            // Writes only when the operation asks for one
            req_d[i].write_mem  = op_valid && op[i].write_en &&
                                  in_window(op[i].write_addr, WRITE_BASE, MEM_DEPTH);
            req_d[i].write_io   = op_valid && op[i].write_en &&
                                  in_window(op[i].write_addr, IO_PORT_BASE, IO_PORT_COUNT);
            req_d[i].write_port = port_of(op[i].write_addr);

            // An aligned base lets the high bits drop
            req_d[i].mem_read_index  = op[i].read_addr & INDEX_MASK;
            req_d[i].mem_write_index = op[i].write_addr & INDEX_MASK;
            req_d[i].write_data      = op[i].write_data;
        end
    end

    // -------------------------------------
    // Request register holds each request for the cycle after its operation

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            req <= '0;
        end else begin
            req <= req_d;
        end
    end

endmodule

`default_nettype wire

/* data_bank.sv */
// -------------------------------------
// One bank: RAM, I/O read select and I/O write strobes.
// Trusts the decoder flags; indices beyond MEM_DEPTH never arrive.
// A read and write to one address in one cycle returns old data.
// io_wren is a one-cycle one-hot strobe.
// -------------------------------------

`timescale 1ns/1ps
`default_nettype none

module data_bank #(
    parameter int unsigned MEM_ADDR_WIDTH = 8,
    parameter int unsigned MEM_DEPTH      = 192,
    parameter int unsigned IO_PORT_COUNT  = 4
) (
    input  wire                                    clock,
    input  wire                                    arst_n,
    input  dpm_pkg::bank_req_t                     req,
    input  dpm_pkg::word_t     [IO_PORT_COUNT-1:0] io_read_data,
    output logic               [IO_PORT_COUNT-1:0] io_wren,
    output dpm_pkg::word_t                         io_write_data,
    output dpm_pkg::bank_rsp_t                     rsp
);

    dpm_pkg::word_t ram [MEM_DEPTH];

    logic [MEM_ADDR_WIDTH-1:0] rd_idx;
    logic [MEM_ADDR_WIDTH-1:0] wr_idx;

    assign rd_idx = req.mem_read_index[MEM_ADDR_WIDTH-1:0];
    assign wr_idx = req.mem_write_index[MEM_ADDR_WIDTH-1:0];

    // -------------------------------------
    // RAM write and registered read

    dpm_pkg::word_t io_sel;
    dpm_pkg::word_t rd_data_q;

    // Port mux that gives zero for an out-of-range port field
    always_comb begin
        io_sel = '0;
        for (int p = 0; p < IO_PORT_COUNT; p++) begin
            if (req.read_port == dpm_pkg::PORT_SEL_WIDTH'(p)) begin
                io_sel = io_read_data[p];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req.write_mem) begin
            ram[wr_idx] <= req.write_data;
        end
        // The read sees the contents from before a same-cycle write
        if (req.read_mem) begin
            rd_data_q <= ram[rd_idx];
        end else begin
            rd_data_q <= io_sel;
        end
    end

    // -------------------------------------
    // I/O write strobe decode

    logic [IO_PORT_COUNT-1:0] wren_d;

    always_comb begin
        for (int p = 0; p < IO_PORT_COUNT; p++) begin
            wren_d[p] = req.write_io && (req.write_port == dpm_pkg::PORT_SEL_WIDTH'(p));
        end
    end

    logic rsp_valid_q;
    logic rsp_read_en_q;
    logic wren_any_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q   <= 1'b0;
            rsp_read_en_q <= 1'b0;
            io_wren       <= '0;
            wren_any_q    <= 1'b0;
        end else begin
            rsp_valid_q   <= req.valid;
            rsp_read_en_q <= req.read_mem || req.read_io;
            io_wren       <= wren_d;
            wren_any_q    <= |wren_d;
        end
    end

    // Holds the last I/O write value between strobes
    always_ff @(posedge clock) begin
        if (req.write_io) begin
            io_write_data <= req.write_data;
        end
    end

    assign rsp = '{
        valid:       rsp_valid_q,
        read_en:     rsp_read_en_q,
        data:        rd_data_q,
        io_wren_any: wren_any_q
    };

endmodule

`default_nettype wire

/* read_collect.sv */
// -------------------------------------
// Final output register for all banks.
// Banks run in lockstep, so bank 0 alone sets rd_valid.
// Disabled reads come out as zero.
// -------------------------------------

`timescale 1ns/1ps
`default_nettype none

module read_collect #(
    parameter int unsigned BANK_COUNT = 2
) (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  dpm_pkg::bank_rsp_t [BANK_COUNT-1:0]  rsp,
    output logic                                 rd_valid,
    output dpm_pkg::word_t     [BANK_COUNT-1:0]  read_data
);

    // -------------------------------------
    // Valid alignment

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rsp[0].valid;
        end
    end

    // -------------------------------------
    // Data with the zero location applied

    always_ff @(posedge clock) begin
        for (int i = 0; i < BANK_COUNT; i++) begin
            if (rsp[i].valid && rsp[i].read_en) begin
                read_data[i] <= rsp[i].data;
            end else begin
                read_data[i] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* datapath_memory.sv */
// -------------------------------------
// Data memory subsystem for the datapath, BANK_COUNT banks.
// Fixed three-cycle read latency, one operation per cycle, no stall.
// All banks share one window set; offsets are resolved upstream.
// Memory depth is the smaller window; accesses past it are dropped.
// I/O ports must sit outside the memory window.
// -------------------------------------

`timescale 1ns/1ps
`default_nettype none

module datapath_memory #(
    parameter int unsigned BANK_COUNT     = 2,
    parameter int unsigned READ_BASE      = 0,
    parameter int unsigned READ_BOUND     = 191,
    parameter int unsigned WRITE_BASE     = 0,
    parameter int unsigned WRITE_BOUND    = 255,
    parameter int unsigned MEM_ADDR_WIDTH = 8,
    parameter int unsigned IO_PORT_COUNT  = 4,
    parameter int unsigned IO_PORT_BASE   = 'h200
) (
    input  wire                                                 clock,
    input  wire                                                 arst_n,
    input  wire                                                 op_valid,
    input  dpm_pkg::bank_op_t [BANK_COUNT-1:0]                  op,
    input  dpm_pkg::word_t    [BANK_COUNT-1:0][IO_PORT_COUNT-1:0] io_read_data,
    output logic              [BANK_COUNT-1:0][IO_PORT_COUNT-1:0] io_wren,
    output dpm_pkg::word_t    [BANK_COUNT-1:0]                  io_write_data,
    output logic                                                rd_valid,
    output dpm_pkg::word_t    [BANK_COUNT-1:0]                  read_data
);

    localparam int unsigned READ_DEPTH  = READ_BOUND - READ_BASE + 1;
    localparam int unsigned WRITE_DEPTH = WRITE_BOUND - WRITE_BASE + 1;
    localparam int unsigned MEM_DEPTH   = (READ_DEPTH <= WRITE_DEPTH) ? READ_DEPTH : WRITE_DEPTH;

    // Elaboration checks on the configuration
    if (IO_PORT_COUNT > (1 << dpm_pkg::PORT_SEL_WIDTH)) begin : g_bad_port_count
        $error("IO_PORT_COUNT exceeds the port index width");
    end
    if ((1 << MEM_ADDR_WIDTH) < MEM_DEPTH) begin : g_bad_mem_width
        $error("MEM_ADDR_WIDTH too narrow for the memory depth");
    end

    // -------------------------------------
    // Decode stage

    dpm_pkg::bank_req_t [BANK_COUNT-1:0] bank_req;
    dpm_pkg::bank_rsp_t [BANK_COUNT-1:0] bank_rsp;

    operand_decode #(
        .BANK_COUNT     (BANK_COUNT),
        .READ_BASE      (READ_BASE),
        .READ_BOUND     (READ_BOUND),
        .WRITE_BASE     (WRITE_BASE),
        .WRITE_BOUND    (WRITE_BOUND),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .IO_PORT_COUNT  (IO_PORT_COUNT),
        .IO_PORT_BASE   (IO_PORT_BASE)
    ) u_operand_decode (
        .clock    (clock),
        .arst_n   (arst_n),
        .op_valid (op_valid),
        .op       (op),
        .req      (bank_req)
    );

    // -------------------------------------
    // Banks

    for (genvar i = 0; i < BANK_COUNT; i++) begin : bank_gen
        data_bank #(
            .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
            .MEM_DEPTH      (MEM_DEPTH),
            .IO_PORT_COUNT  (IO_PORT_COUNT)
        ) u_data_bank (
            .clock         (clock),
            .arst_n        (arst_n),
            .req           (bank_req[i]),
            .io_read_data  (io_read_data[i]),
            .io_wren       (io_wren[i]),
            .io_write_data (io_write_data[i]),
            .rsp           (bank_rsp[i])
        );
    end

    // -------------------------------------
    // Output stage

    read_collect #(
        .BANK_COUNT (BANK_COUNT)
    ) u_read_collect (
        .clock     (clock),
        .arst_n    (arst_n),
        .rsp       (bank_rsp),
        .rd_valid  (rd_valid),
        .read_data (read_data)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
// ----------------------------------------
// Testbench clock and reset source
// Reset is held low for RESET_CYCLES rising edges,
// then released 1 ns after the last one
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* datapath_memory_assert.sv */
// ----------------------------------------
// Concurrent checks bound into datapath_memory
// Covers strobe shape, strobe quiet in reset and the
// fixed three-cycle rd_valid latency
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module datapath_memory_assert #(
    parameter int unsigned BANK_COUNT    = 2,
    parameter int unsigned IO_PORT_COUNT = 4
) (
    input wire                                      clock,
    input wire                                      arst_n,
    input wire                                      op_valid,
    input wire [BANK_COUNT-1:0][IO_PORT_COUNT-1:0]  io_wren,
    input wire                                      rd_valid
);

    // At most one port strobed per bank
    for (genvar b = 0; b < BANK_COUNT; b++) begin : wren_gen
        wren_onehot: assert property (@(posedge clock) $onehot0(io_wren[b]))
            else $error("io_wren of bank %0d has more than one bit set", b);
    end

    wren_quiet_in_reset: assert property (@(posedge clock) !arst_n |-> io_wren == '0)
        else $error("io_wren high while reset is asserted");

    // Operation sampled at E0 gives rd_valid sampled at E3
    rd_valid_latency: assert property (@(posedge clock) disable iff (!arst_n)
        rd_valid == $past(op_valid, 3))
        else $error("rd_valid does not follow op_valid by three cycles");

endmodule

bind datapath_memory datapath_memory_assert #(
    .BANK_COUNT    (BANK_COUNT),
    .IO_PORT_COUNT (IO_PORT_COUNT)
) u_assert (
    .clock    (clock),
    .arst_n   (arst_n),
    .op_valid (op_valid),
    .io_wren  (io_wren),
    .rd_valid (rd_valid)
);

`default_nettype wire

/* tb_datapath_memory.sv */
// ----------------------------------------
// Random testbench for datapath_memory, default windows
// Reads of never-written RAM words are not compared
// io_read_data is fixed after reset for the whole run
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_datapath_memory;

    localparam int BANK_COUNT    = 2;
    localparam int IO_PORT_COUNT = 4;
    localparam int IO_PORT_BASE  = 'h200;
    // Smaller of read window 0..191 and write window 0..255
    localparam int MEM_DEPTH     = 192;
    localparam int LATENCY       = 3;
    localparam int RESET_CYCLES  = 3;

    localparam int N_FILL     = 192;
    localparam int N_READBACK = 64;
    localparam int N_ZERO     = 96;
    localparam int N_IO_RD    = 32;
    localparam int N_IO_WR    = 32;
    localparam int N_PIPE     = 200;
    localparam int TOTAL_OPS  = N_FILL + N_READBACK + N_ZERO + N_IO_RD + N_IO_WR + N_PIPE;
    localparam int CYCLE_LIMIT = TOTAL_OPS + RESET_CYCLES + 5 * (LATENCY + 2) + 50;

    // Address kinds for the generator
    localparam int K_MEM  = 0;
    localparam int K_CLIP = 1;
    localparam int K_GAP  = 2;
    localparam int K_IO   = 3;
    localparam int K_HIGH = 4;
    localparam int K_ANY  = 5;
    localparam int K_SAME = 6;
    localparam int K_ZERO = 7;

    logic                                               clock;
    logic                                               arst_n;
    logic                                               op_valid;
    dpm_pkg::bank_op_t [BANK_COUNT-1:0]                 op;
    dpm_pkg::word_t    [BANK_COUNT-1:0][IO_PORT_COUNT-1:0] io_read_data;
    logic              [BANK_COUNT-1:0][IO_PORT_COUNT-1:0] io_wren;
    dpm_pkg::word_t    [BANK_COUNT-1:0]                 io_write_data;
    logic                                               rd_valid;
    dpm_pkg::word_t    [BANK_COUNT-1:0]                 read_data;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clock  (clock),
        .arst_n (arst_n)
    );

    datapath_memory #(
        .BANK_COUNT     (BANK_COUNT),
        .READ_BASE      (0),
        .READ_BOUND     (191),
        .WRITE_BASE     (0),
        .WRITE_BOUND    (255),
        .MEM_ADDR_WIDTH (8),
        .IO_PORT_COUNT  (IO_PORT_COUNT),
        .IO_PORT_BASE   (IO_PORT_BASE)
    ) dut0 (
        .clock         (clock),
        .arst_n        (arst_n),
        .op_valid      (op_valid),
        .op            (op),
        .io_read_data  (io_read_data),
        .io_wren       (io_wren),
        .io_write_data (io_write_data),
        .rd_valid      (rd_valid),
        .read_data     (read_data)
    );

    // ----------------------------------------
    // Reference model state

    typedef struct {
        int                                       wren_cycle;
        int                                       rd_cycle;
        logic                                     valid;
        logic [BANK_COUNT-1:0]                    known;
        dpm_pkg::word_t [BANK_COUNT-1:0]          data;
        logic [BANK_COUNT-1:0][IO_PORT_COUNT-1:0] wren;
        dpm_pkg::word_t [BANK_COUNT-1:0]          wdata;
    } expect_t;

    expect_t        rd_q[$];
    expect_t        wren_q[$];
    dpm_pkg::word_t model_mem [BANK_COUNT][MEM_DEPTH];
    bit             written [BANK_COUNT][MEM_DEPTH];

    integer seed = 32'h8776;
    int     cycle = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     test_pass0;
    int     test_fail0;
    string  cur_test = "reset";

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic dpm_pkg::addr_t gen_addr(input int kind);
        int k;
        k = kind;
        if (kind == K_ANY) begin
            k = rand_below(8);
            // Memory gets the larger share
            if (k > K_HIGH) k = K_MEM;
        end else if (kind == K_ZERO) begin
            k = K_CLIP + rand_below(3);
            if (k == K_IO) k = K_HIGH;
        end
        case (k)
            K_MEM:   return dpm_pkg::addr_t'(rand_below(MEM_DEPTH));
            K_CLIP:  return dpm_pkg::addr_t'(MEM_DEPTH + rand_below(256 - MEM_DEPTH));
            K_GAP:   return dpm_pkg::addr_t'(256 + rand_below(IO_PORT_BASE - 256));
            K_IO:    return dpm_pkg::addr_t'(IO_PORT_BASE + rand_below(IO_PORT_COUNT));
            default: return dpm_pkg::addr_t'(IO_PORT_BASE + IO_PORT_COUNT +
                                             rand_below(1024 - IO_PORT_BASE - IO_PORT_COUNT));
        endcase
    endfunction

    function automatic bit is_mem(input dpm_pkg::addr_t a);
        return int'(a) < MEM_DEPTH;
    endfunction

    function automatic bit is_io(input dpm_pkg::addr_t a);
        return int'(a) >= IO_PORT_BASE && int'(a) < IO_PORT_BASE + IO_PORT_COUNT;
    endfunction

    // ----------------------------------------
    // Compare tasks

    task automatic check_word(input string name, input dpm_pkg::word_t expected,
                              input dpm_pkg::word_t actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_wren(input string name, input logic [IO_PORT_COUNT-1:0] expected,
                              input logic [IO_PORT_COUNT-1:0] actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_io_word(input string name, input dpm_pkg::word_t expected,
                                 input dpm_pkg::word_t actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // ----------------------------------------
    // Stimulus

    task automatic drive_op(input bit valid, input int rd_kind, input bit wr_en,
                            input int wr_kind);
        expect_t e;
        int      ra;
        int      wa;
        @(posedge clock);
        #1;
        e.wren_cycle = cycle + LATENCY - 1;
        e.rd_cycle   = cycle + LATENCY;
        e.valid      = valid;
        e.known      = '1;
        e.data       = '0;
        e.wren       = '0;
        e.wdata      = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            op[b].read_addr  = gen_addr(rd_kind);
            op[b].write_en   = wr_en;
            op[b].write_addr = (wr_kind == K_SAME) ? op[b].read_addr : gen_addr(wr_kind);
            op[b].write_data = $random(seed);
            ra = int'(op[b].read_addr);
            wa = int'(op[b].write_addr);
            if (valid) begin
                // Read takes the contents from before this operation's write
                if (is_mem(op[b].read_addr)) begin
                    e.known[b] = written[b][ra];
                    e.data[b]  = model_mem[b][ra];
                end else if (is_io(op[b].read_addr)) begin
                    e.data[b] = io_read_data[b][ra - IO_PORT_BASE];
                end
                if (wr_en && is_mem(op[b].write_addr)) begin
                    model_mem[b][wa] = op[b].write_data;
                    written[b][wa]   = 1'b1;
                end else if (wr_en && is_io(op[b].write_addr)) begin
                    e.wren[b][wa - IO_PORT_BASE] = 1'b1;
                    e.wdata[b] = op[b].write_data;
                end
            end
        end
        op_valid = valid;
        rd_q.push_back(e);
        wren_q.push_back(e);
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        test_pass0 = pass_count;
        test_fail0 = fail_count;
    endtask

    task automatic end_test();
        @(posedge clock);
        #1;
        op_valid = 1'b0;
        op = '0;
        while (rd_q.size() != 0 || wren_q.size() != 0) begin
            @(posedge clock);
        end
        $display("test %s done: %0d checks, %0d failed", cur_test,
                 pass_count - test_pass0 + fail_count - test_fail0, fail_count - test_fail0);
    endtask

    // ----------------------------------------
    // Response checker samples at the falling edge where outputs are stable

    always @(negedge clock) begin
        if (arst_n) begin
            if (wren_q.size() != 0 && wren_q[0].wren_cycle == cycle) begin
                for (int b = 0; b < BANK_COUNT; b++) begin
                    check_wren($sformatf("%s bank %0d io_wren", cur_test, b),
                               wren_q[0].wren[b], io_wren[b]);
                    if (wren_q[0].wren[b] != '0) begin
                        check_io_word($sformatf("%s bank %0d io_write_data", cur_test, b),
                                      wren_q[0].wdata[b], io_write_data[b]);
                    end
                end
                void'(wren_q.pop_front());
            end else begin
                for (int b = 0; b < BANK_COUNT; b++) begin
                    check_wren($sformatf("%s bank %0d idle io_wren", cur_test, b),
                               '0, io_wren[b]);
                end
            end
            if (rd_q.size() != 0 && rd_q[0].rd_cycle == cycle) begin
                check_valid($sformatf("%s rd_valid", cur_test), rd_q[0].valid, rd_valid);
                for (int b = 0; b < BANK_COUNT; b++) begin
                    if (rd_q[0].known[b]) begin
                        check_word($sformatf("%s bank %0d read_data", cur_test, b),
                                   rd_q[0].data[b], read_data[b]);
                    end
                end
                void'(rd_q.pop_front());
            end else begin
                check_valid($sformatf("%s idle rd_valid", cur_test), 1'b0, rd_valid);
            end
        end else begin
            // Strobes and rd_valid stay low while reset is asserted
            for (int b = 0; b < BANK_COUNT; b++) begin
                check_wren($sformatf("%s bank %0d io_wren in reset", cur_test, b),
                           '0, io_wren[b]);
            end
            check_valid($sformatf("%s rd_valid in reset", cur_test), 1'b0, rd_valid);
        end
    end

    // Cycle count and run limit
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence

    initial begin
        op_valid = 1'b0;
        op = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int p = 0; p < IO_PORT_COUNT; p++) begin
                io_read_data[b][p] = $random(seed);
            end
        end
        wait (arst_n === 1'b1);

        start_test("mem_round_trip");
        repeat (N_FILL) drive_op(1'b1, K_MEM, 1'b1, K_MEM);
        repeat (N_READBACK) drive_op(1'b1, K_MEM, 1'b0, K_MEM);
        end_test();

        // Half the reads go to memory to show nothing was overwritten
        start_test("zero_location");
        repeat (N_ZERO) drive_op(1'b1, (rand_below(2) != 0) ? K_ZERO : K_MEM, 1'b1, K_ZERO);
        end_test();

        start_test("io_read");
        repeat (N_IO_RD) drive_op(1'b1, K_IO, 1'b0, K_MEM);
        end_test();

        start_test("io_write");
        repeat (N_IO_WR) drive_op(1'b1, K_MEM, 1'b1, K_IO);
        end_test();

        start_test("pipeline_order");
        repeat (N_PIPE) begin
            drive_op(rand_below(4) != 0, K_ANY, rand_below(2) != 0,
                     (rand_below(4) == 0) ? K_SAME : K_ANY);
        end
        end_test();

        $display("Summary: %0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
dpm_pkg.sv
operand_decode.sv
data_bank.sv
read_collect.sv
datapath_memory.sv
tb_clock.sv
datapath_memory_assert.sv
tb_datapath_memory.sv

/* run.sh */
#!/bin/sh
# Build and run the datapath memory testbench with Verilator.
# The simulation output goes to sim.log, and the log decides the result.

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_datapath_memory -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
